// ==== source/sys_video_pkg.sv ====
`default_nettype none

package sys_video_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int IO_W       = 16;
	localparam int LINE_W     = 12;
	localparam int LED_W      = 8;
	localparam int SYNC_CNT_W = 16;
	localparam int CMD_W      = 8;

	// Composite sync enable in the config word
	localparam int CFG_CSYNC_BIT = 3;

	//////////////////////////////////////////////////
	// HPS command codes
	//////////////////////////////////////////////////

	typedef enum logic [CMD_W-1:0] {
		CMD_NONE      = 8'h00,
		CMD_CFG       = 8'h01,
		CMD_LED       = 8'h25,
		CMD_SYNC_LINE = 8'h38
	} cmd_e;

	// Register values after reset
	localparam logic [IO_W-1:0]   CFG_RST     = '0;
	localparam logic [LED_W-1:0]  LED_RST     = '0;
	localparam logic [LINE_W-1:0] VS_LINE_RST = '0;

endpackage

`default_nettype wire

// ==== source/hps_cmd_decoder.sv ====
`default_nettype none

module hps_cmd_decoder
	import sys_video_pkg::*;
(
	input  wire               clk_sys,
	input  wire               resetd,

	input  wire               i_io_uio,
	input  wire               i_io_strobe,
	input  wire  [IO_W-1:0]   i_io_din,

	// {power, disk, user}
	input  wire  [2:0]        i_led_status,

	output logic              o_csync_en,
	output logic [LINE_W-1:0] o_vs_line,
	output logic [LED_W-1:0]  o_led
);

	logic              has_cmd;
	cmd_e              cmd;
	cmd_e              cmd_in;

	logic [IO_W-1:0]   cfg;
	logic [LED_W-1:0]  led_ovr;
	logic [LED_W-1:0]  led_state;
	logic [LINE_W-1:0] vs_line;
	logic [LED_W-1:0]  status_map;

	//////////////////////////////////////////////////
	// Command framing
	//////////////////////////////////////////////////

	// Codes this block does not handle fall back to NONE
	always_comb begin
		case (i_io_din[CMD_W-1:0])
			CMD_CFG,
			CMD_LED,
			CMD_SYNC_LINE: cmd_in = cmd_e'(i_io_din[CMD_W-1:0]);
			default:       cmd_in = CMD_NONE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd       <= CMD_NONE;
			cfg       <= CFG_RST;
			led_ovr   <= LED_RST;
			led_state <= LED_RST;
			vs_line   <= VS_LINE_RST;
		end else if (!i_io_uio) begin
			// Frame closed
			has_cmd <= 1'b0;
			cmd     <= CMD_NONE;
		end else if (i_io_strobe) begin
			if (!has_cmd) begin
				// First word of the frame
				has_cmd <= 1'b1;
				cmd     <= cmd_in;
			end else begin
				// Each data word rewrites the target
				case (cmd)
					CMD_CFG:       cfg <= i_io_din;
					CMD_LED:       {led_ovr, led_state} <= i_io_din;
					CMD_SYNC_LINE: vs_line <= i_io_din[LINE_W-1:0];
					default: begin
					end
				endcase
			end
		end
	end

	assign o_csync_en = cfg[CFG_CSYNC_BIT];
	assign o_vs_line  = vs_line;

	//////////////////////////////////////////////////
	// LED mix
	//////////////////////////////////////////////////

	// Board LED positions of the core status bits
	always_comb begin
		status_map    = '0;
		status_map[0] = i_led_status[0];
		status_map[2] = i_led_status[1];
		status_map[4] = i_led_status[2];
	end

	// Override bits select the written state per LED
	always_ff @(posedge clk_sys) begin
		o_led <= (led_ovr & led_state) | (~led_ovr & status_map);
	end

endmodule

`default_nettype wire

// ==== source/sync_polarity_fix.sv ====
`default_nettype none

module sync_polarity_fix
	import sys_video_pkg::*;
(
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;
	logic                  pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Length of the phase that just ended
			if (!s2 && s1)
				low_len <= cnt;
			if (s2 && !s1)
				high_len <= cnt;

			cnt <= cnt + 1'b1;
			if (s2 != s1)
				cnt <= '0;

			// Longer high phase means the sync pulse is low
			pol <= (high_len > low_len);
		end
	end

	assign o_sync = s2 ^ pol;

endmodule

`default_nettype wire

// ==== source/sync_combiner.sv ====
`default_nettype none

module sync_combiner
	import sys_video_pkg::*;
(
	input  wire               clk_sys,
	input  wire               resetd,

	// Active-high syncs
	input  wire               i_hs,
	input  wire               i_vs,
	input  wire               i_de,

	input  wire               i_csync_en,
	input  wire  [LINE_W-1:0] i_vs_line,

	output logic              o_hs_out,
	output logic              o_vs_out,
	output logic              o_video_sync
);

	logic                  hs_d;
	logic                  hs_rise;
	logic                  hs_fall;

	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;
	logic [SYNC_CNT_W-1:0] serr_set;
	logic                  serr_hs;
	logic                  serr_hs_nxt;

	logic [LINE_W-1:0]     line_cnt;
	logic [LINE_W-1:0]     sync_line;
	logic [1:0]            blank_cnt;

	assign hs_rise = i_hs & ~hs_d;
	assign hs_fall = ~i_hs & hs_d;

	//////////////////////////////////////////////////
	// Composite sync
	//////////////////////////////////////////////////

	// Serration pulse starts one hsync width before the next line
	assign serr_set = line_len - hs_len;

	always_comb begin
		serr_hs_nxt = serr_hs;
		if (!i_vs)
			serr_hs_nxt = i_hs;
		else if (hs_rise)
			serr_hs_nxt = 1'b0;
		else if (h_cnt == serr_set)
			serr_hs_nxt = 1'b1;
	end

	// h_cnt runs from each hsync rise
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_d     <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			serr_hs  <= 1'b0;
		end else begin
			hs_d    <= i_hs;
			serr_hs <= serr_hs_nxt;
			h_cnt   <= h_cnt + 1'b1;
			if (hs_rise) begin
				h_cnt    <= '0;
				line_len <= h_cnt;
			end
			if (hs_fall)
				hs_len <= h_cnt;
		end
	end

	// One register stage on the output syncs
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_hs_out <= 1'b0;
			o_vs_out <= 1'b0;
		end else begin
			o_hs_out <= i_csync_en ? (i_vs ^ serr_hs_nxt) : i_hs;
			o_vs_out <= i_vs;
		end
	end

	//////////////////////////////////////////////////
	// Video sync line marker
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			line_cnt     <= '0;
			sync_line    <= '0;
			blank_cnt    <= '0;
			o_video_sync <= 1'b0;
		end else begin
			if (hs_rise) begin
				o_video_sync <= (line_cnt == sync_line);
				line_cnt     <= line_cnt + 1'b1;
				if (!blank_cnt[1]) begin
					blank_cnt <= blank_cnt + 1'b1;
					// Second blank line restarts the frame count
					if (blank_cnt[0]) begin
						sync_line <= line_cnt - i_vs_line;
						line_cnt  <= '0;
					end
				end
			end
			// Active video wins over the count above
			if (i_de)
				blank_cnt <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/sys_video_top.sv ====
`default_nettype none

module sys_video_top
	import sys_video_pkg::*;
(
	input  wire              clk_sys,
	input  wire              resetd,

	// HPS command port
	input  wire              i_io_uio,
	input  wire              i_io_strobe,
	input  wire  [IO_W-1:0]  i_io_din,

	// Core video and status
	input  wire              i_hs_core,
	input  wire              i_vs_core,
	input  wire              i_de_core,
	input  wire  [2:0]       i_led_status,

	output logic             o_hs_fix,
	output logic             o_vs_fix,
	output logic             o_hs_out,
	output logic             o_vs_out,
	output logic             o_video_sync,
	output logic [LED_W-1:0] o_led
);

	logic              csync_en;
	logic [LINE_W-1:0] vs_line;
	logic              hs_fix;
	logic              vs_fix;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	hps_cmd_decoder u_cmd (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_uio     (i_io_uio),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.i_led_status (i_led_status),
		.o_csync_en   (csync_en),
		.o_vs_line    (vs_line),
		.o_led        (o_led)
	);

	//////////////////////////////////////////////////
	// Video sync path
	//////////////////////////////////////////////////

	sync_polarity_fix u_fix_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs_core),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix u_fix_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs_core),
		.o_sync  (vs_fix)
	);

	sync_combiner u_comb (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_hs         (hs_fix),
		.i_vs         (vs_fix),
		.i_de         (i_de_core),
		.i_csync_en   (csync_en),
		.i_vs_line    (vs_line),
		.o_hs_out     (o_hs_out),
		.o_vs_out     (o_vs_out),
		.o_video_sync (o_video_sync)
	);

	assign o_hs_fix = hs_fix;
	assign o_vs_fix = vs_fix;

endmodule

`default_nettype wire

// ==== verif/tb_sys_video_model.svh ====
`ifndef TB_SYS_VIDEO_MODEL_SVH
`define TB_SYS_VIDEO_MODEL_SVH

//////////////////////////////////////////////////
// Model state
//////////////////////////////////////////////////

// Two-flop delay, phase lengths and polarity of one sync
typedef struct packed {
	logic                  d1;
	logic                  d2;
	logic [SYNC_CNT_W-1:0] run;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;
	logic                  pol;
} fix_model_t;

typedef struct packed {
	logic                  hs_d;
	logic [SYNC_CNT_W-1:0] pos;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;
	logic                  serr;
	logic                  hs_out;
	logic                  vs_out;
	logic [LINE_W-1:0]     line;
	logic [LINE_W-1:0]     sync_line;
	logic [1:0]            blank;
	logic                  mark;
} comb_model_t;

typedef struct packed {
	logic              has_cmd;
	cmd_e              cmd;
	logic [IO_W-1:0]   cfg;
	logic [LED_W-1:0]  ovr;
	logic [LED_W-1:0]  state;
	logic [LINE_W-1:0] vs_line;
	logic [LED_W-1:0]  led;
} dec_model_t;

//////////////////////////////////////////////////
// Reference functions
//////////////////////////////////////////////////

function automatic logic [LED_W-1:0] led_mix(input logic [LED_W-1:0] ovr,
		input logic [LED_W-1:0] state, input logic [2:0] status);
	logic [LED_W-1:0] map;
	logic [LED_W-1:0] led;
	int               i;
	// User, disk and power land on LEDs 0, 2 and 4
	map = {3'b000, status[2], 1'b0, status[1], 1'b0, status[0]};
	for (i = 0; i < LED_W; i++)
		led[i] = ovr[i] ? state[i] : map[i];
	return led;
endfunction

function automatic dec_model_t dec_step(input dec_model_t s, input logic uio,
		input logic strobe, input logic [IO_W-1:0] din);
	dec_model_t n;
	n = s;
	if (!uio) begin
		n.has_cmd = 1'b0;
		n.cmd     = CMD_NONE;
	end else if (strobe && !s.has_cmd) begin
		n.has_cmd = 1'b1;
		case (din[7:0])
			8'h01:   n.cmd = CMD_CFG;
			8'h25:   n.cmd = CMD_LED;
			8'h38:   n.cmd = CMD_SYNC_LINE;
			default: n.cmd = CMD_NONE;
		endcase
	end else if (strobe) begin
		if (s.cmd == CMD_CFG)
			n.cfg = din;
		else if (s.cmd == CMD_LED)
			{n.ovr, n.state} = din;
		else if (s.cmd == CMD_SYNC_LINE)
			n.vs_line = din[LINE_W-1:0];
	end
	return n;
endfunction

function automatic fix_model_t fix_step(input fix_model_t s, input logic sync_in);
	fix_model_t n;
	n     = s;
	n.d1  = sync_in;
	n.d2  = s.d1;
	n.pol = s.high_len > s.low_len;
	if (s.d1 == s.d2) begin
		n.run = s.run + 16'd1;
	end else begin
		// An edge closes the phase held in d2
		n.run = '0;
		if (s.d2)
			n.high_len = s.run;
		else
			n.low_len = s.run;
	end
	return n;
endfunction

function automatic comb_model_t comb_step(input comb_model_t s, input logic hs,
		input logic vs, input logic de, input logic csync, input logic [LINE_W-1:0] offs);
	comb_model_t n;
	logic        rise;
	logic        fall;
	n      = s;
	rise   = hs && !s.hs_d;
	fall   = !hs && s.hs_d;
	n.hs_d = hs;
	// Serrated hsync inside vsync
	if (!vs)
		n.serr = hs;
	else if (rise)
		n.serr = 1'b0;
	else if (s.pos == s.line_len - s.hs_len)
		n.serr = 1'b1;
	n.hs_out = csync ? (vs ^ n.serr) : hs;
	n.vs_out = vs;
	n.pos    = rise ? '0 : s.pos + 16'd1;
	if (rise)
		n.line_len = s.pos;
	if (fall)
		n.hs_len = s.pos;
	if (rise) begin
		n.mark = (s.line == s.sync_line);
		n.line = s.line + 12'd1;
		if (s.blank == 2'd1) begin
			n.sync_line = s.line - offs;
			n.line      = '0;
		end
		if (s.blank < 2'd2)
			n.blank = s.blank + 2'd1;
	end
	if (de)
		n.blank = '0;
	return n;
endfunction

task automatic check_equal(input string name, input logic [IO_W-1:0] got,
		input logic [IO_W-1:0] exp);
	if (got !== exp) begin
		$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("SOME TESTS FAILED");
		$fatal(1, "mismatch on %s", name);
	end
endtask

`endif

// ==== verif/tb_sys_video.sv ====
`default_nettype none

module tb_sys_video
	import sys_video_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 20000;

	logic             clk_sys;
	logic             resetd;
	logic             i_io_uio;
	logic             i_io_strobe;
	logic [IO_W-1:0]  i_io_din;
	logic             i_hs_core;
	logic             i_vs_core;
	logic             i_de_core;
	logic [2:0]       i_led_status;
	logic             o_hs_fix;
	logic             o_vs_fix;
	logic             o_hs_out;
	logic             o_vs_out;
	logic             o_video_sync;
	logic [LED_W-1:0] o_led;

	int               seed;
	int               frames;
	int               h_total;
	int               h_w;
	int               v_total;
	int               v_w;
	int               hpos;
	int               vpos;
	logic             h_inv;
	logic             v_inv;
	logic             checking;
	logic             pol_settled;
	logic [1:0]       hs_hist;
	logic [1:0]       vs_hist;
	logic             csync;
	logic             hs_f;
	logic             vs_f;
	logic [LED_W-1:0] led_next;
	logic [LED_W-1:0] led_before;

`include "tb_sys_video_model.svh"

	fix_model_t  fix_h_m;
	fix_model_t  fix_v_m;
	comb_model_t comb_m;
	dec_model_t  dec_m;

	sys_video_top uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Core video timing
	//////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (resetd) begin
			hpos = 0;
			vpos = 0;
		end else if (hpos >= h_total - 1) begin
			hpos = 0;
			if (vpos >= v_total - 1) begin
				vpos   = 0;
				frames = frames + 1;
			end else
				vpos = vpos + 1;
		end else
			hpos = hpos + 1;
		i_hs_core <= (hpos < h_w) ^ h_inv;
		i_vs_core <= (vpos < v_w) ^ v_inv;
		i_de_core <= (vpos >= v_w + 3) && (hpos >= h_w + 2);
	end

	//////////////////////////////////////////////////
	// Model and comparison
	//////////////////////////////////////////////////

	always begin
		@(posedge clk_sys);
		// Sync levels as the core meant them before inversion
		hs_hist  = {hs_hist[0], i_hs_core ^ h_inv};
		vs_hist  = {vs_hist[0], i_vs_core ^ v_inv};
		csync    = dec_m.cfg[CFG_CSYNC_BIT];
		hs_f     = fix_h_m.d2 ^ fix_h_m.pol;
		vs_f     = fix_v_m.d2 ^ fix_v_m.pol;
		led_next = led_mix(dec_m.ovr, dec_m.state, i_led_status);
		if (resetd) begin
			fix_h_m = '0;
			fix_v_m = '0;
			comb_m  = '0;
			dec_m   = '0;
		end else begin
			comb_m  = comb_step(comb_m, hs_f, vs_f, i_de_core, csync, dec_m.vs_line);
			fix_h_m = fix_step(fix_h_m, i_hs_core);
			fix_v_m = fix_step(fix_v_m, i_vs_core);
			dec_m   = dec_step(dec_m, i_io_uio, i_io_strobe, i_io_din);
		end
		dec_m.led = led_next;
		@(negedge clk_sys);
		if (checking) begin
			check_equal("o_hs_fix", 16'(o_hs_fix), 16'(fix_h_m.d2 ^ fix_h_m.pol));
			check_equal("o_vs_fix", 16'(o_vs_fix), 16'(fix_v_m.d2 ^ fix_v_m.pol));
			check_equal("o_hs_out", 16'(o_hs_out), 16'(comb_m.hs_out));
			check_equal("o_vs_out", 16'(o_vs_out), 16'(comb_m.vs_out));
			check_equal("o_video_sync", 16'(o_video_sync), 16'(comb_m.mark));
			check_equal("o_led", 16'(o_led), 16'(dec_m.led));
			// Plain mode is hsync one cycle late
			if (!csync)
				check_equal("o_hs_out", 16'(o_hs_out), 16'(hs_f));
			if (pol_settled) begin
				check_equal("o_hs_fix", 16'(o_hs_fix), 16'(hs_hist[1]));
				check_equal("o_vs_fix", 16'(o_vs_fix), 16'(vs_hist[1]));
			end
		end
	end

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic logic [IO_W-1:0] rand_word();
		return 16'($random(seed));
	endfunction

	task automatic wait_frames(input int n);
		int target;
		int cycles;
		target = frames + n;
		cycles = 0;
		while (frames < target) begin
			@(negedge clk_sys);
			cycles = cycles + 1;
			if (cycles > TIMEOUT) begin
				$display("Timeout: the video timing did not complete %0d frames", n);
				$display("SOME TESTS FAILED");
				$fatal(1, "timeout waiting for frames");
			end
		end
	endtask

	task automatic put_word(input logic [IO_W-1:0] w);
		@(negedge clk_sys);
		i_io_strobe = 1'b1;
		i_io_din    = w;
		@(negedge clk_sys);
		i_io_strobe = 1'b0;
	endtask

	task automatic send_frame(input logic [IO_W-1:0] code, input logic [IO_W-1:0] first,
			input logic [IO_W-1:0] last);
		@(negedge clk_sys);
		i_io_uio = 1'b1;
		put_word(code);
		// The second data word rewrites the first
		put_word(first);
		put_word(last);
		@(negedge clk_sys);
		i_io_uio = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	initial begin
		seed         = 95;
		frames       = 0;
		h_total      = 32;
		h_w          = 4;
		v_total      = 14;
		v_w          = 2;
		h_inv        = 1'b0;
		v_inv        = 1'b0;
		checking     = 1'b0;
		pol_settled  = 1'b0;
		resetd       = 1'b1;
		i_io_uio     = 1'b0;
		i_io_strobe  = 1'b0;
		i_io_din     = '0;
		i_hs_core    <= 1'b0;
		i_vs_core    <= 1'b0;
		i_de_core    <= 1'b0;
		i_led_status = 3'($random(seed));
		repeat (5) @(negedge clk_sys);
		resetd = 1'b0;

		check_equal("o_led", 16'(o_led), 16'(led_mix('0, '0, i_led_status)));
		check_equal("o_hs_out", 16'(o_hs_out), 16'h0000);
		check_equal("o_vs_out", 16'(o_vs_out), 16'h0000);
		check_equal("o_video_sync", 16'(o_video_sync), 16'h0000);
		checking = 1'b1;

		// Active-low syncs with random widths
		h_total = 24 + rand_below(17);
		h_w     = 2 + rand_below(5);
		v_total = 12 + rand_below(5);
		v_w     = 2 + rand_below(2);
		h_inv   = 1'b1;
		v_inv   = 1'b1;
		wait_frames(3);
		pol_settled = 1'b1;
		wait_frames(2);
		pol_settled = 1'b0;
		h_inv       = 1'b0;
		v_inv       = 1'b0;
		wait_frames(3);
		pol_settled = 1'b1;

		repeat (6) begin
			i_led_status = 3'($random(seed));
			send_frame(16'h0025, rand_word(), rand_word());
		end
		// Stray strobes and an unknown code
		led_before = o_led;
		put_word(16'h0025);
		put_word(rand_word());
		send_frame(16'h0042, rand_word(), rand_word());
		repeat (2) @(negedge clk_sys);
		check_equal("o_led", 16'(o_led), 16'(led_before));

		send_frame(16'h0001, rand_word(), rand_word() | 16'h0008);
		wait_frames(3);
		send_frame(16'h0001, rand_word(), rand_word() & ~16'h0008);
		wait_frames(2);

		send_frame(16'h0038, rand_word(), 16'(rand_below(v_total)));
		wait_frames(4);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/sys_video_pkg.sv
source/hps_cmd_decoder.sv
source/sync_polarity_fix.sv
source/sync_combiner.sv
source/sys_video_top.sv
+incdir+verif
verif/tb_sys_video.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sys_video
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
